// File: compile.f
+incdir+design
design/StorePathTypes.sv
design/StoreRouter.sv
design/StoreQueue.sv
design/StoreCommitter.sv
design/StorePerfCounter.sv
design/StorePath.sv
testbench/ClockGen.sv
testbench/StorePath_assert.sv
testbench/StorePathChecker.sv
testbench/StorePathTb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = StorePathTb
RTL_TOP    = StorePath
FILELIST   = compile.f
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qxF '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/StorePathTb.sv
// Store path testbench
// Random committed stores over the memory map against random busy bursts
// on the memory port, with the checker and the port assertions attached

`include "storePath_settings.svh"

module StorePathTb
    import StorePathTypes::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_COMMITS = 200;
    localparam int SEED = 92;
    // Generous cycles per commit plus reset and drain
    localparam int WATCHDOG_CYCLES = NUM_COMMITS * 20 + 100;

    logic clk;
    logic arstN;
    logic commitValid;
    logic commitReady;
    CommittedStore commitEntry;
    logic memAccessWE;
    StoreAddrPath memAccessAddr;
    StoreDataPath memAccessWriteData;
    logic memAccessWriteBusy;
    logic serialWE;
    SerialDataPath serialWriteData;
    PerfCounters perfCounter;
    logic stimDone;
    logic reportDone;
    int errorTotal;
    int seed;

    ClockGen clockGen (
        .clk(clk),
        .arstN(arstN)
    );

    StorePath i_StorePath (
        .clk(clk),
        .arstN(arstN),
        .commitValid(commitValid),
        .commitReady(commitReady),
        .commitEntry(commitEntry),
        .memAccessWE(memAccessWE),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .memAccessWriteBusy(memAccessWriteBusy),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData),
        .perfCounter(perfCounter)
    );

    StorePathChecker storePathChecker (
        .clk(clk),
        .arstN(arstN),
        .commitValid(commitValid),
        .commitReady(commitReady),
        .commitEntry(commitEntry),
        .memAccessWE(memAccessWE),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData),
        .perfCounter(perfCounter),
        .stimDone(stimDone),
        .reportDone(reportDone),
        .errorTotal(errorTotal)
    );

    bind StorePath StorePath_assert storePathAssert (
        .clk(clk),
        .arstN(arstN),
        .commitValid(commitValid),
        .commitReady(commitReady),
        .commitEntry(commitEntry),
        .memAccessWE(memAccessWE),
        .memAccessWriteBusy(memAccessWriteBusy),
        .serialWE(serialWE),
        .headValid(headValid),
        .headReady(headReady),
        .head(head)
    );

    // Roughly 60% memory, 25% serial, 15% outside both regions
    function automatic CommittedStore randomCommit();
        logic [31:0] pick;
        CommittedStore store;
        pick = $unsigned($random(seed)) % 32'd100;
        store.data = $random(seed);
        if (pick < 32'd60) begin
            store.addr = $random(seed) & 32'h0000_FFFF;
        end
        else if (pick < 32'd85) begin
            store.addr = `STORE_SERIAL_ADDR;
        end
        else begin
            store.addr = 32'h0001_0000 + ($unsigned($random(seed)) & 32'h0FFF_FFFF);
        end
        return store;
    endfunction

    // Commit stimulus, random draws only at rising edges
    initial begin
        seed = SEED;
        commitValid <= 1'b0;
        commitEntry <= '0;
        stimDone <= 1'b0;
        wait (arstN === 1'b1);
        @(posedge clk);
        for (int i = 0; i < NUM_COMMITS; i++) begin
            commitValid <= 1'b1;
            commitEntry <= randomCommit();
            @(posedge clk);
            while (!commitReady) begin
                @(posedge clk);
            end
            if ($unsigned($random(seed)) % 32'd4 == 32'd0) begin
                commitValid <= 1'b0;
                @(posedge clk);
            end
        end
        commitValid <= 1'b0;
        stimDone <= 1'b1;
    end

    // Busy bursts of 1 to 12 cycles, drawn at falling edges
    initial begin
        int burstLength;
        memAccessWriteBusy <= 1'b0;
        wait (arstN === 1'b1);
        while (stimDone !== 1'b1) begin
            @(negedge clk);
            burstLength = 1 + int'($unsigned($random(seed)) % 32'd12);
            @(posedge clk);
            memAccessWriteBusy <= ~memAccessWriteBusy;
            repeat (burstLength - 1) @(posedge clk);
        end
        @(posedge clk);
        memAccessWriteBusy <= 1'b0;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the store path did not drain within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        wait (reportDone === 1'b1);
        if (errorTotal == 0 && i_StorePath.storePathAssert.assertFailures == 0) begin
            $display("*** PASSED ***");
        end
        else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : StorePathTb

// File: testbench/StorePathChecker.sv
// Store path checker
// Predicts where every accepted store must go, follows the memory and
// serial ports against that prediction and compares the counters at the end

`include "storePath_settings.svh"

module StorePathChecker
    import StorePathTypes::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic commitValid,
    input  logic commitReady,
    input  CommittedStore commitEntry,
    input  logic memAccessWE,
    input  StoreAddrPath memAccessAddr,
    input  StoreDataPath memAccessWriteData,
    input  logic serialWE,
    input  SerialDataPath serialWriteData,
    input  PerfCounters perfCounter,
    input  logic stimDone,
    output logic reportDone,
    output int errorTotal
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {ROUTE_MEMORY, ROUTE_SERIAL, ROUTE_DROP} Route;

    CommittedStore memQueue [$];
    SerialDataPath serialQueue [$];
    int memExpected = 0;
    int serialExpected = 0;
    int dropExpected = 0;
    int valueErrors = 0;
    int unexpectedWrites = 0;
    int counterErrors = 0;
    int otherErrors = 0;
    int stallCycles = 0;

    // Memory map as the store path must apply it
    function automatic Route predictRoute(input StoreAddrPath addr);
        if (addr == `STORE_SERIAL_ADDR) begin
            return ROUTE_SERIAL;
        end
        if (addr < `STORE_MEM_LIMIT) begin
            return ROUTE_MEMORY;
        end
        return ROUTE_DROP;
    endfunction

    task automatic recordCommit(input CommittedStore store);
        case (predictRoute(store.addr))
            ROUTE_MEMORY: begin
                memQueue.push_back(store);
                memExpected++;
            end
            ROUTE_SERIAL: begin
                serialQueue.push_back(store.data[7:0]);
                serialExpected++;
            end
            default: dropExpected++;
        endcase
    endtask

    task automatic checkMemoryWrite(input StoreAddrPath addr, input StoreDataPath data);
        CommittedStore expected;
        if (memQueue.size() == 0) begin
            $display("Error at %0t: memory write to %h with no memory store pending",
                $time, addr);
            unexpectedWrites++;
        end
        else begin
            expected = memQueue.pop_front();
            if (addr !== expected.addr) begin
                $display("** Error at %0t: memAccessAddr expected %h, actual %h",
                    $time, expected.addr, addr);
                valueErrors++;
            end
            if (data !== expected.data) begin
                $display("** Error at %0t: memAccessWriteData expected %h, actual %h",
                    $time, expected.data, data);
                valueErrors++;
            end
        end
    endtask

    task automatic checkSerialWrite(input SerialDataPath data);
        SerialDataPath expected;
        if (serialQueue.size() == 0) begin
            $display("Error at %0t: serial write of %h with no serial store pending",
                $time, data);
            unexpectedWrites++;
        end
        else begin
            expected = serialQueue.pop_front();
            if (data !== expected) begin
                $display("** Error at %0t: serialWriteData expected %h, actual %h",
                    $time, expected, data);
                valueErrors++;
            end
        end
    endtask

    // Router register plus a full queue is the only state that may stall
    task automatic checkStall(input int pending);
        if (pending != `STORE_QUEUE_DEPTH + 1) begin
            $display("** Error at %0t: commitReady expected 1, actual 0 (%0d in flight)",
                $time, pending);
            valueErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, actual %b",
                $time, name, expected, actual);
            otherErrors++;
        end
    endtask

    task automatic compareCounter(input string name, input StoreCounterPath actual,
                                  input int expected);
        if (actual !== StoreCounterPath'(expected)) begin
            $display("** Error at %0t: %s expected %0d, actual %0d",
                $time, name, expected, actual);
            counterErrors++;
        end
    endtask

    // Handshakes and write enables sampled at the clock edge
    always @(posedge clk) begin
        if (arstN) begin
            if (commitValid && commitReady) begin
                recordCommit(commitEntry);
            end
            if (memAccessWE) begin
                checkMemoryWrite(memAccessAddr, memAccessWriteData);
            end
            if (serialWE) begin
                checkSerialWrite(serialWriteData);
            end
            if (commitValid && !commitReady) begin
                stallCycles++;
                checkStall(memQueue.size() + serialQueue.size());
            end
        end
    end

    initial begin
        reportDone = 1'b0;
        errorTotal = 0;
        @(negedge clk);
        if (arstN === 1'b0) begin
            checkBit("commitReady", commitReady, 1'b0);
        end
        wait (arstN === 1'b1);
        @(negedge clk);
        checkBit("commitReady", commitReady, 1'b1);
        checkBit("memAccessWE", memAccessWE, 1'b0);
        checkBit("serialWE", serialWE, 1'b0);
        compareCounter("perfCounter.memStores", perfCounter.memStores, 0);
        compareCounter("perfCounter.serialStores", perfCounter.serialStores, 0);
        compareCounter("perfCounter.droppedStores", perfCounter.droppedStores, 0);
        wait (stimDone === 1'b1);
        do begin
            @(negedge clk);
        end while (memQueue.size() != 0 || serialQueue.size() != 0);
        // Counters trail their events by a cycle
        repeat (2) @(negedge clk);
        compareCounter("perfCounter.memStores", perfCounter.memStores, memExpected);
        compareCounter("perfCounter.serialStores", perfCounter.serialStores, serialExpected);
        compareCounter("perfCounter.droppedStores", perfCounter.droppedStores, dropExpected);
        if (stallCycles == 0) begin
            $display("Error: commitReady never fell, the path was never filled");
            otherErrors++;
        end
        $display("Errors: %0d value, %0d unexpected write, %0d counter, %0d other",
            valueErrors, unexpectedWrites, counterErrors, otherErrors);
        errorTotal = valueErrors + unexpectedWrites + counterErrors + otherErrors;
        reportDone = 1'b1;
    end

endmodule : StorePathChecker

// File: testbench/StorePath_assert.sv
// Store path port assertions
// Bound into the store path top to watch the write ports, the queue pops
// and the commit handshake

module StorePath_assert
    import StorePathTypes::*;
(
    input logic clk,
    input logic arstN,
    input logic commitValid,
    input logic commitReady,
    input CommittedStore commitEntry,
    input logic memAccessWE,
    input logic memAccessWriteBusy,
    input logic serialWE,
    input logic headValid,
    input logic headReady,
    input RoutedStore head
);
    timeunit 1ns;
    timeprecision 100ps;

    int assertFailures = 0;
    logic popMemory;
    logic popSerial;

    assign popMemory = headValid && headReady && (head.target == TARGET_MEMORY);
    assign popSerial = headValid && headReady && (head.target == TARGET_SERIAL);

    // Only one port writes in a cycle
    exclusiveWrite: assert property (@(posedge clk) disable iff (!arstN)
        !(memAccessWE && serialWE))
        else begin
            $error("memory and serial write enables high together");
            assertFailures++;
        end

    memoryWaitsForBusy: assert property (@(posedge clk) disable iff (!arstN)
        memAccessWE |-> $past(!memAccessWriteBusy))
        else begin
            $error("memory write issued while the port was busy");
            assertFailures++;
        end

    // One write enable cycle per popped entry
    memoryWritePerPop: assert property (@(posedge clk) disable iff (!arstN)
        memAccessWE == $past(popMemory))
        else begin
            $error("memory write enable does not match a single queue pop");
            assertFailures++;
        end

    serialWritePerPop: assert property (@(posedge clk) disable iff (!arstN)
        serialWE == $past(popSerial))
        else begin
            $error("serial write enable does not match a single queue pop");
            assertFailures++;
        end

    commitHeld: assert property (@(posedge clk) disable iff (!arstN)
        (commitValid && !commitReady) |=> (commitValid && $stable(commitEntry)))
        else begin
            $error("commit dropped or changed before it was accepted");
            assertFailures++;
        end

endmodule : StorePath_assert

// File: testbench/ClockGen.sv
// Clock and reset generator
// 10 ns clock, reset held low over the first two rising edges

module ClockGen (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule : ClockGen

// File: design/StorePath.sv
// Store path top
// Router, store queue, committer and performance counters joined
// between the commit port and the memory and serial ports

module StorePath
    import StorePathTypes::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic commitValid,
    output logic commitReady,
    input  CommittedStore commitEntry,
    output logic memAccessWE,
    output StoreAddrPath memAccessAddr,
    output StoreDataPath memAccessWriteData,
    input  logic memAccessWriteBusy,
    output logic serialWE,
    output SerialDataPath serialWriteData,
    output PerfCounters perfCounter
);

    // Router to queue
    logic routedValid;
    logic routedReady;
    RoutedStore routed;

    // Queue to committer
    logic headValid;
    logic headReady;
    RoutedStore head;

    logic dropPulse;

    StoreRouter storeRouter (
        .clk(clk),
        .arstN(arstN),
        .commitValid(commitValid),
        .commitEntry(commitEntry),
        .routedReady(routedReady),
        .commitReady(commitReady),
        .routedValid(routedValid),
        .routed(routed),
        .dropPulse(dropPulse)
    );

    StoreQueue storeQueue (
        .clk(clk),
        .arstN(arstN),
        .routedValid(routedValid),
        .routed(routed),
        .headReady(headReady),
        .routedReady(routedReady),
        .headValid(headValid),
        .head(head)
    );

    StoreCommitter storeCommitter (
        .clk(clk),
        .arstN(arstN),
        .headValid(headValid),
        .head(head),
        .memAccessWriteBusy(memAccessWriteBusy),
        .headReady(headReady),
        .memAccessWE(memAccessWE),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData)
    );

    StorePerfCounter storePerfCounter (
        .clk(clk),
        .arstN(arstN),
        .dropPulse(dropPulse),
        .memAccessWE(memAccessWE),
        .serialWE(serialWE),
        .perfCounter(perfCounter)
    );

endmodule : StorePath

// File: design/StorePerfCounter.sv
// Store performance counters
// Saturating counts of memory writes, serial writes and dropped stores

module StorePerfCounter
    import StorePathTypes::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic dropPulse,
    input  logic memAccessWE,
    input  logic serialWE,
    output PerfCounters perfCounter
);

    // Sticks at all ones
    function automatic StoreCounterPath satIncrement(input StoreCounterPath value);
        return (value == '1) ? value : value + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            perfCounter <= '0;
        end
        else begin
            if (memAccessWE) begin
                perfCounter.memStores <= satIncrement(perfCounter.memStores);
            end
            if (serialWE) begin
                perfCounter.serialStores <= satIncrement(perfCounter.serialStores);
            end
            if (dropPulse) begin
                perfCounter.droppedStores <= satIncrement(perfCounter.droppedStores);
            end
        end
    end

endmodule : StorePerfCounter

// File: design/StoreCommitter.sv
// Store committer
// Drains the store queue head to the memory write port or the serial
// port, one registered write per popped entry

module StoreCommitter
    import StorePathTypes::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic headValid,
    input  RoutedStore head,
    input  logic memAccessWriteBusy,
    output logic headReady,
    output logic memAccessWE,
    output StoreAddrPath memAccessAddr,
    output StoreDataPath memAccessWriteData,
    output logic serialWE,
    output SerialDataPath serialWriteData
);

    logic pop;
    logic popMemory;
    logic popSerial;

    // Serial port never stalls; memory waits for busy to clear
    assign headReady = (head.target == TARGET_SERIAL) || !memAccessWriteBusy;

    assign pop = headValid && headReady;
    assign popMemory = pop && (head.target == TARGET_MEMORY);
    assign popSerial = pop && (head.target == TARGET_SERIAL);

    // One-cycle write enables
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memAccessWE <= 1'b0;
            serialWE <= 1'b0;
        end
        else begin
            memAccessWE <= popMemory;
            serialWE <= popSerial;
        end
    end

    always_ff @(posedge clk) begin
        if (popMemory) begin
            memAccessAddr <= head.addr;
            memAccessWriteData <= head.data;
        end
        if (popSerial) begin
            // Low byte only
            serialWriteData <= head.data[7:0];
        end
    end

endmodule : StoreCommitter

// File: design/StoreQueue.sv
// Store queue
// Circular buffer of routed stores between the router and the committer.
// Absorbs the stores held back while the memory port is busy.

`include "storePath_settings.svh"

module StoreQueue
    import StorePathTypes::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic routedValid,
    input  RoutedStore routed,
    input  logic headReady,
    output logic routedReady,
    output logic headValid,
    output RoutedStore head
);

    localparam int DEPTH = `STORE_QUEUE_DEPTH;
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0] QueuePtr;

    RoutedStore entries [DEPTH];
    QueuePtr headPtr;
    QueuePtr tailPtr;
    logic [COUNT_WIDTH-1:0] count;
    logic pushEn;
    logic popEn;

    // Wraps at the last entry, so any depth works
    function automatic QueuePtr nextPtr(input QueuePtr ptr);
        return (ptr == QueuePtr'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign routedReady = (count != COUNT_WIDTH'(DEPTH));
    assign headValid = (count != '0);
    assign head = entries[headPtr];

    assign pushEn = routedValid && routedReady;
    assign popEn = headValid && headReady;

    always_ff @(posedge clk) begin
        if (pushEn) begin
            entries[tailPtr] <= routed;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end
        else begin
            if (pushEn) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (popEn) begin
                headPtr <= nextPtr(headPtr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({pushEn, popEn})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : StoreQueue

// File: design/StoreRouter.sv
// Store router
// Decodes each committed store against the memory map, tags it with its
// target and holds it in a single output register. Stores outside both
// regions are accepted, discarded and flagged on dropPulse.

`include "storePath_settings.svh"

module StoreRouter
    import StorePathTypes::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic commitValid,
    input  CommittedStore commitEntry,
    input  logic routedReady,
    output logic commitReady,
    output logic routedValid,
    output RoutedStore routed,
    output logic dropPulse
);

    logic accept;
    logic inRange;
    StoreTarget target;

    // Free register, or one that drains this cycle
    // Held low while in reset
    assign commitReady = arstN && (!routedValid || routedReady);
    assign accept = commitValid && commitReady;

    // Memory map decode
    always_comb begin
        target = TARGET_MEMORY;
        inRange = 1'b0;
        if (commitEntry.addr == `STORE_SERIAL_ADDR) begin
            target = TARGET_SERIAL;
            inRange = 1'b1;
        end
        else if (commitEntry.addr < `STORE_MEM_LIMIT) begin
            inRange = 1'b1;
        end
    end

    assign dropPulse = accept && !inRange;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            routedValid <= 1'b0;
        end
        else if (accept && inRange) begin
            routedValid <= 1'b1;
        end
        else if (routedReady) begin
            routedValid <= 1'b0;
        end
    end

    // Payload stage
    always_ff @(posedge clk) begin
        if (accept && inRange) begin
            routed.target <= target;
            routed.addr <= commitEntry.addr;
            routed.data <= commitEntry.data;
        end
    end

endmodule : StoreRouter

// File: design/StorePathTypes.sv
// Store path types
// Committed and routed store entries, the target tag and the
// performance counter bundle

`include "storePath_settings.svh"

package StorePathTypes;

    typedef logic [`STORE_ADDR_WIDTH-1:0] StoreAddrPath;
    typedef logic [`STORE_DATA_WIDTH-1:0] StoreDataPath;
    typedef logic [`STORE_COUNTER_WIDTH-1:0] StoreCounterPath;

    // Byte-wide serial output
    typedef logic [7:0] SerialDataPath;

    // Store as it leaves commit
    typedef struct packed {
        StoreAddrPath addr;
        StoreDataPath data;
    } CommittedStore;

    // Destination picked by the memory map
    typedef enum logic [0:0] {
        TARGET_MEMORY = 1'b0,
        TARGET_SERIAL = 1'b1
    } StoreTarget;

    // Store tagged with its destination
    typedef struct packed {
        StoreTarget target;
        StoreAddrPath addr;
        StoreDataPath data;
    } RoutedStore;

    typedef struct packed {
        StoreCounterPath memStores;
        StoreCounterPath serialStores;
        StoreCounterPath droppedStores;
    } PerfCounters;

endpackage : StorePathTypes

// File: design/storePath_settings.svh
// Store path settings
// Widths, store queue depth and the memory map shared by the store path

`ifndef STORE_PATH_SETTINGS_SVH
`define STORE_PATH_SETTINGS_SVH

`define STORE_ADDR_WIDTH 32
`define STORE_DATA_WIDTH 32

// Entries in the store queue
`define STORE_QUEUE_DEPTH 4

// Memory map
`define STORE_MEM_LIMIT 32'h0001_0000
`define STORE_SERIAL_ADDR 32'h4000_0000

`define STORE_COUNTER_WIDTH 16

`endif
